// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps
LINTFLAGS = --lint-only --timing --timescale 1ns/1ps
TOP       = i2cMasterTb
FILELIST  = sources.f
BUILDDIR  = obj_dir
PASSTEXT  = All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)
	@out="$$(./$(BUILDDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASSTEXT)"

clean:
	rm -rf $(BUILDDIR)

// ==== rtl/i2cMaster.sv ====
`timescale 1ns/1ps

module i2cMaster (
    input  logic              clk,
    input  logic              reset,
    input  i2cPkg::i2cRequest request,
    input  logic              transmitValid,
    output logic              transmitReady,
    output i2cPkg::i2cResult  result,
    output logic              receiveValid,
    output logic              busy,
    inout  wire               scl,
    inout  wire               sda
);
    import i2cPkg::*;

    shiftOp op;
    logic   timerEnable;
    logic   phaseDone;
    logic   sampledSda;
    logic   shiftMsb;
    logic   heldAck;
    logic   sclDrive;
    logic   sdaDrive;

    // quarter-bit pacing
    i2cPhaseTimer i_i2cPhaseTimer (
        .clk         (clk),
        .reset       (reset),
        .timerEnable (timerEnable),
        .phaseDone   (phaseDone)
    );

    // byte and ack storage
    i2cShifter i_i2cShifter (
        .clk        (clk),
        .reset      (reset),
        .op         (op),
        .request    (request),
        .sampledSda (sampledSda),
        .shiftMsb   (shiftMsb),
        .heldAck    (heldAck),
        .result     (result)
    );

    // pins are read back directly, sequencer syncs them
    i2cSequencer i_i2cSequencer (
        .clk           (clk),
        .reset         (reset),
        .command       (request.command),
        .transmitValid (transmitValid),
        .phaseDone     (phaseDone),
        .sclIn         (scl),
        .sdaIn         (sda),
        .shiftMsb      (shiftMsb),
        .heldAck       (heldAck),
        .transmitReady (transmitReady),
        .receiveValid  (receiveValid),
        .busy          (busy),
        .timerEnable   (timerEnable),
        .op            (op),
        .sampledSda    (sampledSda),
        .sclDrive      (sclDrive),
        .sdaDrive      (sdaDrive)
    );

    // open drain, a high level means let the pull-up win
    assign scl = sclDrive ? 1'bz : 1'b0;
    assign sda = sdaDrive ? 1'bz : 1'b0;

endmodule

// ==== rtl/i2cPhaseTimer.sv ====
`timescale 1ns/1ps

module i2cPhaseTimer (
    input  logic clk,
    input  logic reset,
    input  logic timerEnable,
    output logic phaseDone
);
    import i2cPkg::*;

    // remaining clocks in the current phase
    logic [phaseCountWidth-1:0] count;

    // down-counter, reloads at the end of every phase
    // dropping the enable puts it back to a full phase
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= phaseCountWidth'(phaseClocks - 1);
        end else if (!timerEnable) begin
            count <= phaseCountWidth'(phaseClocks - 1);
        end else if (count == '0) begin
            count <= phaseCountWidth'(phaseClocks - 1);
        end else begin
            count <= count - 1'b1;
        end
    end

    // one clock strobe on the last cycle of a phase
    // first strobe lands phaseClocks cycles after the enable rises
    assign phaseDone = timerEnable && (count == '0);

endmodule

// ==== rtl/i2cPkg.sv ====
package i2cPkg;

    // clocks in one quarter-bit phase
    localparam int phaseClocks = 5;

    // counter width, kept at one bit minimum for tiny phase lengths
    localparam int phaseCountWidth = (phaseClocks > 1) ? $clog2(phaseClocks) : 1;

    // data bits in a byte, the ack bit follows them
    localparam int bitsPerByte = 8;

    // host commands
    typedef enum logic [1:0] {
        cmdStart = 2'd0,
        cmdStop  = 2'd1,
        cmdWrite = 2'd2,
        cmdRead  = 2'd3
    } i2cCommand;

    // shifter operations issued by the sequencer
    typedef enum logic [1:0] {
        opHold       = 2'd0,
        opLoad       = 2'd1,
        opShift      = 2'd2,
        opCaptureAck = 2'd3
    } shiftOp;

    // sequencer states
    // init phases serve start and stop, cycle phases serve each byte bit
    typedef enum logic [3:0] {
        stIdle   = 4'd0,
        stDecode = 4'd1,
        stInit1  = 4'd2,
        stInit2  = 4'd3,
        stInit3  = 4'd4,
        stInit4  = 4'd5,
        stCycle1 = 4'd6,
        stCycle2 = 4'd7,
        stCycle3 = 4'd8,
        stCycle4 = 4'd9
    } seqState;

    // one host request, ack is what the master sends after a read
    typedef struct packed {
        i2cCommand              command;
        logic [bitsPerByte-1:0] data;
        logic                   ack;
    } i2cRequest;

    // byte result, ack is what was sampled in the ninth bit
    typedef struct packed {
        logic [bitsPerByte-1:0] data;
        logic                   ack;
    } i2cResult;

endpackage

// ==== rtl/i2cSequencer.sv ====
`timescale 1ns/1ps

module i2cSequencer (
    input  logic              clk,
    input  logic              reset,
    input  i2cPkg::i2cCommand command,
    input  logic              transmitValid,
    input  logic              phaseDone,
    input  logic              sclIn,
    input  logic              sdaIn,
    input  logic              shiftMsb,
    input  logic              heldAck,
    output logic              transmitReady,
    output logic              receiveValid,
    output logic              busy,
    output logic              timerEnable,
    output i2cPkg::shiftOp    op,
    output logic              sampledSda,
    output logic              sclDrive,
    output logic              sdaDrive
);
    import i2cPkg::*;

    seqState    state;
    seqState    nextState;
    i2cCommand  commandReg;
    i2cCommand  commandNext;
    logic [3:0] bitCount;
    logic [3:0] bitCountNext;
    logic       sclNext;
    logic       sdaNext;
    logic       readyNext;
    logic       validNext;
    logic [1:0] sclSync;
    logic [1:0] sdaSync;
    logic       lastBit;

    // two flop synchronizers on the pins, idle bus reads high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sclSync <= 2'b11;
            sdaSync <= 2'b11;
        end else begin
            sclSync <= {sclSync[0], sclIn};
            sdaSync <= {sdaSync[0], sdaIn};
        end
    end

    assign sampledSda = sdaSync[1];
    // ninth bit of a byte carries the ack
    assign lastBit    = (bitCount == 4'(bitsPerByte));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= stIdle;
            commandReg    <= cmdStart;
            bitCount      <= '0;
            sclDrive      <= 1'b1;
            sdaDrive      <= 1'b1;
            transmitReady <= 1'b0;
            receiveValid  <= 1'b0;
        end else begin
            state         <= nextState;
            commandReg    <= commandNext;
            bitCount      <= bitCountNext;
            sclDrive      <= sclNext;
            sdaDrive      <= sdaNext;
            transmitReady <= readyNext;
            receiveValid  <= validNext;
        end
    end

    // busy from the accept edge on, the timer runs only in the phase states
    assign busy        = (state != stIdle);
    assign timerEnable = busy && (state != stDecode);

    always_comb begin
        nextState    = state;
        commandNext  = commandReg;
        bitCountNext = bitCount;
        sclNext      = sclDrive;
        sdaNext      = sdaDrive;
        readyNext    = 1'b0;
        validNext    = 1'b0;
        op           = opHold;
        case (state)
            stIdle: begin
                // accept, data and ack go straight into the shifter
                if (transmitValid) begin
                    readyNext    = 1'b1;
                    commandNext  = command;
                    bitCountNext = '0;
                    op           = opLoad;
                    nextState    = stDecode;
                end
            end
            stDecode: begin
                if (commandReg == cmdStart || commandReg == cmdStop) begin
                    nextState = stInit1;
                end else begin
                    nextState = stCycle1;
                end
            end
            // start and stop: scl low, sda set, scl high, sda edge
            stInit1: begin
                if (phaseDone) begin
                    sclNext   = 1'b0;
                    nextState = stInit2;
                end
            end
            stInit2: begin
                if (phaseDone) begin
                    sdaNext   = (commandReg == cmdStart);
                    nextState = stInit3;
                end
            end
            stInit3: begin
                if (phaseDone) begin
                    sclNext   = 1'b1;
                    nextState = stInit4;
                end
            end
            stInit4: begin
                // sda falls for start, rises for stop, scl is high here
                if (phaseDone) begin
                    sdaNext   = (commandReg == cmdStop);
                    nextState = stIdle;
                end
            end
            // byte bits: scl low, sda set, scl high, sample
            stCycle1: begin
                if (phaseDone) begin
                    sclNext   = 1'b0;
                    nextState = stCycle2;
                end
            end
            stCycle2: begin
                if (phaseDone) begin
                    if (lastBit) begin
                        // read sends the host ack, write lets the target answer
                        sdaNext = (commandReg == cmdRead) ? heldAck : 1'b1;
                    end else begin
                        sdaNext = (commandReg == cmdWrite) ? shiftMsb : 1'b1;
                    end
                    nextState = stCycle3;
                end
            end
            stCycle3: begin
                if (phaseDone) begin
                    sclNext   = 1'b1;
                    nextState = stCycle4;
                end
            end
            stCycle4: begin
                // target may stretch, hold here until scl really reads high
                if (phaseDone && sclSync[1]) begin
                    if (lastBit) begin
                        // sda is left where bit 8 put it while scl stays high
                        // the next command's low phase moves it without a false stop
                        op        = opCaptureAck;
                        validNext = 1'b1;
                        nextState = stIdle;
                    end else begin
                        op           = opShift;
                        bitCountNext = bitCount + 4'd1;
                        nextState    = stCycle1;
                    end
                end
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

endmodule

// ==== rtl/i2cShifter.sv ====
`timescale 1ns/1ps

module i2cShifter (
    input  logic              clk,
    input  logic              reset,
    input  i2cPkg::shiftOp    op,
    input  i2cPkg::i2cRequest request,
    input  logic              sampledSda,
    output logic              shiftMsb,
    output logic              heldAck,
    output i2cPkg::i2cResult  result
);
    import i2cPkg::*;

    // byte register, transmit data goes out of the top
    // and received bits come in at the bottom
    logic [bitsPerByte-1:0] dataReg;

    // ack to send on a read, then the ack seen on the bus
    logic                   ackReg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dataReg <= '0;
            ackReg  <= 1'b0;
        end else begin
            case (op)
                opLoad: begin
                    dataReg <= request.data;
                    ackReg  <= request.ack;
                end
                // bus level moves in on every data bit
                // on a write this is our own bit coming back
                opShift: begin
                    dataReg <= {dataReg[bitsPerByte-2:0], sampledSda};
                end
                opCaptureAck: begin
                    ackReg <= sampledSda;
                end
                default: begin
                    dataReg <= dataReg;
                    ackReg  <= ackReg;
                end
            endcase
        end
    end

    assign shiftMsb = dataReg[bitsPerByte-1];
    assign heldAck  = ackReg;
    assign result   = '{data: dataReg, ack: ackReg};

endmodule

// ==== sources.f ====
rtl/i2cPkg.sv
rtl/i2cPhaseTimer.sv
rtl/i2cShifter.sv
rtl/i2cSequencer.sv
rtl/i2cMaster.sv
tests/i2cChecker.sv
tests/i2cMasterTb.sv

// ==== tests/i2cChecker.sv ====
`timescale 1ns/1ps

module i2cChecker (
    input  logic              clk,
    input  logic              reset,
    input  i2cPkg::i2cRequest request,
    input  logic              transmitValid,
    input  logic              transmitReady,
    input  i2cPkg::i2cResult  result,
    input  logic              receiveValid,
    input  logic              busy,
    input  logic              scl,
    input  logic              sda,
    input  logic              targetAck,
    input  logic [7:0]        expectedData,
    input  int                stretchLimit,
    input  logic              runDone,
    output int                errorCount,
    output int                testsChecked
);
    import i2cPkg::*;

    // bus totals, free running, differenced per command
    int                   riseTotal = 0;
    int                   startTotal = 0;
    int                   stopTotal = 0;
    logic [bitsPerByte:0] busBits = '0;

    // expectations latched at acceptance
    i2cRequest  held = '0;
    logic       heldTargetAck = 1'b1;
    logic [7:0] heldData = '0;
    int         heldStretch = 0;
    int         riseMark = 0;
    int         startMark = 0;
    int         stopMark = 0;
    int         cycles = 0;
    int         validCount = 0;
    int         errors = 0;
    int         errorMark = 0;
    int         checked = 0;
    int         failedTests = 0;
    logic       testActive = 1'b0;
    logic       readyExpected = 1'b0;
    logic       resetSeen = 1'b0;

    assign errorCount   = errors;
    assign testsChecked = checked;

    // sda level at every scl rise, last nine rises form a byte
    always @(posedge scl) begin
        riseTotal = riseTotal + 1;
        busBits   = {busBits[bitsPerByte-1:0], sda};
    end

    // sda falling with scl high is a start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            startTotal = startTotal + 1;
        end
    end

    // and rising is a stop
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            stopTotal = stopTotal + 1;
        end
    end

    function automatic string commandName(input i2cCommand command);
        case (command)
            cmdStart: return "START";
            cmdStop:  return "STOP";
            cmdWrite: return "WRITE";
            default:  return "READ";
        endcase
    endfunction

    task automatic expectEqual(input string name, input int expected, input int actual);
        if (expected != actual) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic reportTest(input string label);
        if (errors == errorMark) begin
            $display("test %0d %s: ok", checked, label);
        end else begin
            failedTests = failedTests + 1;
            $display("test %0d %s: FAILED", checked, label);
        end
        checked = checked + 1;
    endtask

    // outputs idle and bus released straight after reset
    task automatic checkResetState();
        errorMark = errors;
        expectEqual("busy", 0, int'(busy));
        expectEqual("transmitReady", 0, int'(transmitReady));
        expectEqual("receiveValid", 0, int'(receiveValid));
        expectEqual("scl", 1, int'(scl));
        expectEqual("sda", 1, int'(sda));
        reportTest("reset state");
    endtask

    task automatic checkByteResult();
        if (held.command == cmdWrite) begin
            expectEqual("result.ack", int'(heldTargetAck), int'(result.ack));
        end else if (held.command == cmdRead) begin
            expectEqual("result.data", int'(heldData), int'(result.data));
            expectEqual("result.ack", int'(held.ack), int'(result.ack));
        end
    endtask

    task automatic startTest();
        held          = request;
        heldTargetAck = targetAck;
        heldData      = expectedData;
        heldStretch   = stretchLimit;
        riseMark      = riseTotal;
        startMark     = startTotal;
        stopMark      = stopTotal;
        cycles        = 0;
        validCount    = 0;
        errorMark     = errors;
        testActive    = 1'b1;
        readyExpected = 1'b1;
    endtask

    task automatic finishTest();
        int starts;
        int stops;
        starts     = startTotal - startMark;
        stops      = stopTotal - stopMark;
        testActive = 1'b0;
        if (held.command == cmdWrite || held.command == cmdRead) begin
            expectEqual("receiveValid pulses", 1, validCount);
            expectEqual("scl rises", bitsPerByte + 1, riseTotal - riseMark);
            // no sda edge may happen under a high scl inside a byte
            expectEqual("start and stop edges", 0, starts + stops);
            if (held.command == cmdWrite) begin
                expectEqual("sda data bits", int'(heldData), int'(busBits[bitsPerByte:1]));
                expectEqual("sda ack bit", int'(heldTargetAck), int'(busBits[0]));
            end else begin
                expectEqual("sda ack bit", int'(held.ack), int'(busBits[0]));
            end
        end else begin
            expectEqual("receiveValid pulses", 0, validCount);
            expectEqual("busy latency", 2 + 4 * phaseClocks, cycles);
            expectEqual("start edges", (held.command == cmdStart) ? 1 : 0, starts);
            expectEqual("stop edges", (held.command == cmdStop) ? 1 : 0, stops);
        end
        reportTest($sformatf("%s data %h stretch %0d", commandName(held.command),
                             heldData, heldStretch));
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (!resetSeen) begin
                resetSeen = 1'b1;
                checkResetState();
            end
            cycles = cycles + 1;
            // ready is a single pulse right after each accept
            expectEqual("transmitReady", int'(readyExpected), int'(transmitReady));
            readyExpected = 1'b0;
            if (receiveValid) begin
                validCount = validCount + 1;
                checkByteResult();
            end
            if (testActive && !busy) begin
                finishTest();
            end
            if (transmitValid && !busy) begin
                startTest();
            end
        end
    end

    always @(posedge runDone) begin
        $display("tests checked %0d, tests failed %0d, check errors %0d",
                 checked, failedTests, errors);
    end

endmodule

// ==== tests/i2cMasterTb.sv ====
`timescale 1ns/1ps

module i2cMasterTb;
    import i2cPkg::*;

    localparam int maxTests = 32;

    logic      clk;
    logic      reset;
    i2cRequest request;
    logic      transmitValid;
    logic      transmitReady;
    i2cResult  result;
    logic      receiveValid;
    logic      busy;
    tri1       scl;
    tri1       sda;

    // test table
    i2cCommand  commands [maxTests];
    logic [7:0] dataBytes [maxTests];
    logic       hostAcks [maxTests];
    logic       targetAcks [maxTests];
    int         stretchLimits [maxTests];
    logic [7:0] readBytes [maxTests];
    logic [7:0] expectedBytes [maxTests];
    int         numTests = 0;
    int         parseErrors = 0;
    int         testIndex = -1;

    // longest stretch in the stimulus in clocks
    int         longestStretch = 0;

    // per command values for the checker
    logic       targetAck;
    logic [7:0] expectedData;
    int         stretchLimit;
    logic       runDone;
    int         errorCount;
    int         testsChecked;

    // target side of the bus
    logic sclHold = 1'b0;
    logic sdaLow = 1'b0;
    int   servedTest = -1;
    int   fallCount = 0;
    int   holdCycles = 0;
    int   cycleCount = 0;
    int   cycleLimit = 0;

    assign scl = sclHold ? 1'b0 : 1'bz;
    assign sda = sdaLow ? 1'b0 : 1'bz;

    i2cMaster i_i2cMaster (
        .clk           (clk),
        .reset         (reset),
        .request       (request),
        .transmitValid (transmitValid),
        .transmitReady (transmitReady),
        .result        (result),
        .receiveValid  (receiveValid),
        .busy          (busy),
        .scl           (scl),
        .sda           (sda)
    );

    i2cChecker i_i2cChecker (
        .clk           (clk),
        .reset         (reset),
        .request       (request),
        .transmitValid (transmitValid),
        .transmitReady (transmitReady),
        .result        (result),
        .receiveValid  (receiveValid),
        .busy          (busy),
        .scl           (scl),
        .sda           (sda),
        .targetAck     (targetAck),
        .expectedData  (expectedData),
        .stretchLimit  (stretchLimit),
        .runDone       (runDone),
        .errorCount    (errorCount),
        .testsChecked  (testsChecked)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic readStimulus();
        int    fd;
        int    fields;
        int    cmdCode;
        int    dataValue;
        int    hostAck;
        int    tgtAck;
        int    stretch;
        int    readValue;
        int    expectValue;
        string line;
        fd = $fopen("tests/i2cStimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open tests/i2cStimulus.txt");
            parseErrors = parseErrors + 1;
        end else begin
            while (!$feof(fd) && numTests < maxTests) begin
                line = "";
                void'($fgets(line, fd));
                // skip comment and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%d %h %h %h %d %h %h", cmdCode, dataValue,
                                     hostAck, tgtAck, stretch, readValue, expectValue);
                    if (fields == 7) begin
                        commands[numTests]      = i2cCommand'(cmdCode[1:0]);
                        dataBytes[numTests]     = dataValue[7:0];
                        hostAcks[numTests]      = hostAck[0];
                        targetAcks[numTests]    = tgtAck[0];
                        stretchLimits[numTests] = stretch;
                        readBytes[numTests]     = readValue[7:0];
                        expectedBytes[numTests] = expectValue[7:0];
                        if (stretch > longestStretch) begin
                            longestStretch = stretch;
                        end
                        numTests = numTests + 1;
                    end else begin
                        $display("ERROR: stimulus line could not be parsed: %s", line);
                        parseErrors = parseErrors + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one command from the host side and a wait for the engine to go idle
    task automatic runTest(input int index);
        while (busy) @(negedge clk);
        testIndex        = index;
        targetAck        = targetAcks[index];
        expectedData     = expectedBytes[index];
        stretchLimit     = stretchLimits[index];
        request.command  = commands[index];
        request.data     = dataBytes[index];
        request.ack      = hostAcks[index];
        transmitValid    = 1'b1;
        @(negedge clk);
        transmitValid = 1'b0;
        while (busy) @(negedge clk);
        @(negedge clk);
    endtask

    // target acks writes, serves read bytes MSB first and stretches scl
    initial begin
        // stretch lengths are drawn here from a fixed seed
        void'($urandom(32'hc202_7f59));
        forever begin
            @(negedge scl);
            if (testIndex >= 0) begin
                if (testIndex != servedTest) begin
                    servedTest = testIndex;
                    fallCount  = 0;
                end
                @(negedge clk);
                if (commands[testIndex] == cmdWrite && fallCount == bitsPerByte) begin
                    sdaLow = !targetAcks[testIndex];
                end else if (commands[testIndex] == cmdRead && fallCount < bitsPerByte) begin
                    sdaLow = !readBytes[testIndex][bitsPerByte - 1 - fallCount];
                end else begin
                    sdaLow = 1'b0;
                end
                fallCount = fallCount + 1;
                if (stretchLimits[testIndex] > 0) begin
                    holdCycles = 1 + int'($urandom % 32'(stretchLimits[testIndex]));
                    sclHold    = 1'b1;
                    repeat (holdCycles) @(negedge clk);
                    sclHold = 1'b0;
                end
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("ERROR: timeout after %0d cycles, the DUT did not finish", cycleCount);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        reset         = 1'b1;
        request       = '0;
        transmitValid = 1'b0;
        targetAck     = 1'b1;
        expectedData  = '0;
        stretchLimit  = 0;
        runDone       = 1'b0;
        readStimulus();
        // every command bounded as a full byte with the longest stretch on each phase
        cycleLimit = numTests * (bitsPerByte + 1) * 4 * (phaseClocks + longestStretch) + 1000;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < numTests; i++) begin
            runTest(i);
        end
        runDone = 1'b1;
        @(negedge clk);
        if (parseErrors == 0 && numTests > 0 && errorCount == 0
            && testsChecked == numTests + 1) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tests/i2cStimulus.txt ====
# command (0 start, 1 stop, 2 write, 3 read), data, ack, targetAck, stretchCycles,
# targetReadByte, expectedData; stretchCycles is decimal, the rest hex, targetAck 0 = ACK
0 00 1 1 0 00 00
2 a0 1 0 0 00 a0
2 3c 1 0 0 00 3c
2 5a 1 1 0 00 5a
0 00 1 1 0 00 00
2 a1 1 0 0 00 a1
3 00 0 1 0 c5 c5
3 00 1 1 0 3e 3e
1 00 1 1 0 00 00
0 00 1 1 0 00 00
2 96 1 0 24 00 96
3 00 0 1 30 e7 e7
3 00 1 1 18 81 81
1 00 1 1 0 00 00
